//--- bench/graph_algorithm_control_sva.sv
`timescale 1ns/1ns
`default_nettype none

module graph_algorithm_control_sva (
	input wire clock,
	input wire rstn,
	input wire enabled,
	input wire read_command_bus_grant_latched,
	input wire bus_request_int,
	input wire vertex_job_valid,
	input wire vertex_job_request,
	input wire read_command_bus_request,
	input wire read_command_valid
);

	// Failed assertions so far
	int failures = 0;

	////////////////////////////////////////////////////////////
	// Read command bus
	////////////////////////////////////////////////////////////

	// Issue only right after a latched grant met a held command
	command_after_grant: assert property (@(posedge clock) disable iff (!rstn)
		read_command_valid |-> $past(read_command_bus_grant_latched && bus_request_int))
	else begin
		failures++;
		$error("read_command_valid without a latched grant and a held command");
	end

	// Request drops only once its command went out
	request_falls_on_issue: assert property (@(posedge clock) disable iff (!rstn)
		$fell(read_command_bus_request) |-> $past(read_command_valid))
	else begin
		failures++;
		$error("read_command_bus_request fell with no command issued");
	end

	////////////////////////////////////////////////////////////
	// Job protocol
	////////////////////////////////////////////////////////////

	// Quiet right after reset
	idle_after_reset: assert property (@(posedge clock)
		$rose(rstn) |-> !vertex_job_request && !read_command_bus_request && !read_command_valid)
	else begin
		failures++;
		$error("vertex_job_request or bus outputs high right after reset");
	end

	// An accepted job pulls the request down within 3 cycles
	request_falls_after_job: assert property (@(posedge clock) disable iff (!rstn)
		vertex_job_valid && vertex_job_request && enabled |-> ##[1:3] !vertex_job_request)
	else begin
		failures++;
		$error("vertex_job_request stayed high after an accepted job");
	end

endmodule

bind graph_algorithm_control graph_algorithm_control_sva i_graph_algorithm_control_sva (
	.clock                         (clock),
	.rstn                          (rstn),
	.enabled                       (enabled),
	.read_command_bus_grant_latched(read_command_bus_grant_latched),
	.bus_request_int               (bus_request_int),
	.vertex_job_valid              (vertex_job_valid),
	.vertex_job_request            (vertex_job_request),
	.read_command_bus_request      (read_command_bus_request),
	.read_command_valid            (read_command_valid)
);

`default_nettype wire

//--- bench/graph_algorithm_control_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "graph_cu_params.svh"

module graph_algorithm_control_tb;

	localparam int TIMEOUT = 5000;

	logic clock = 1'b0;
	logic rstn;
	logic enabled_in;
	logic vertex_job_valid;
	logic [`GRAPH_VERTEX_BITS-1:0] vertex_job_id;
	logic [`GRAPH_ADDR_BITS-1:0] vertex_job_edge_offset;
	logic [`GRAPH_EDGE_COUNT_BITS-1:0] vertex_job_edge_count;
	logic vertex_job_request;
	logic read_command_bus_grant;
	logic read_command_bus_request;
	logic read_command_valid;
	logic [`GRAPH_VERTEX_BITS-1:0] read_command_vertex;
	logic [`GRAPH_ADDR_BITS-1:0] read_command_address;
	logic [`GRAPH_COUNTER_BITS-1:0] vertex_job_counter_done;
	logic [`GRAPH_COUNTER_BITS-1:0] edge_job_counter_done;

	// Reference model, keyed by vertex id
	logic [`GRAPH_ADDR_BITS-1:0] next_address [int];
	int remaining [int];
	int exp_vertex = 0;
	int exp_edge = 0;

	logic [15:0] lfsr = 16'd75;
	logic random_grant = 1'b0;
	int errors = 0;
	int tests = 0;
	int test_errors;
	int commands_seen = 0;
	int switches;
	int last_vertex;
	int seen_vertex;
	int snap_commands;
	int snap_vertex;
	int snap_edge;
	int stretch;

	always #20 clock = ~clock;

	graph_algorithm_control i_graph_algorithm_control (
		.clock                   (clock),
		.rstn                    (rstn),
		.enabled_in              (enabled_in),
		.vertex_job_valid        (vertex_job_valid),
		.vertex_job_id           (vertex_job_id),
		.vertex_job_edge_offset  (vertex_job_edge_offset),
		.vertex_job_edge_count   (vertex_job_edge_count),
		.vertex_job_request      (vertex_job_request),
		.read_command_bus_grant  (read_command_bus_grant),
		.read_command_bus_request(read_command_bus_request),
		.read_command_valid      (read_command_valid),
		.read_command_vertex     (read_command_vertex),
		.read_command_address    (read_command_address),
		.vertex_job_counter_done (vertex_job_counter_done),
		.edge_job_counter_done   (edge_job_counter_done)
	);

	////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////

	// Galois LFSR, one step per bit
	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
			value = {value[30:0], lfsr[0]};
		end
		return value;
	endfunction

	// Advance to 2 ns past the next rising edges
	task automatic step(input int n);
		repeat (n) begin
			@(posedge clock);
			#2;
			if (random_grant) begin
				read_command_bus_grant = (random_bits(1) != 0);
			end
		end
	endtask

	task automatic submit_job(input int id, input int count);
		logic [`GRAPH_ADDR_BITS-1:0] offset;
		int t;
		offset = random_bits(32);
		t = 0;
		while (!vertex_job_request) begin
			if (t == TIMEOUT) begin
				$display("Timed out at %0t waiting for vertex_job_request", $time);
				errors++;
				break;
			end
			step(1);
			t++;
		end
		next_address[id] = offset;
		remaining[id] = count;
		exp_vertex++;
		exp_edge += count;
		vertex_job_id = `GRAPH_VERTEX_BITS'(id);
		vertex_job_edge_offset = offset;
		vertex_job_edge_count = `GRAPH_EDGE_COUNT_BITS'(count);
		vertex_job_valid = 1'b1;
		step(1);
		vertex_job_valid = 1'b0;
		step(4);
	endtask

	// Wait for all jobs to drain, then compare totals
	task automatic check_totals();
		int t;
		t = 0;
		while (vertex_job_counter_done != exp_vertex || read_command_bus_request) begin
			if (t == TIMEOUT) begin
				$display("Timed out at %0t waiting for the vertex jobs to finish", $time);
				errors++;
				break;
			end
			step(1);
			t++;
		end
		step(3);
		if (vertex_job_counter_done != exp_vertex) begin
			$display("MISMATCH at %0t: vertex total %0d, expected %0d",
				$time, vertex_job_counter_done, exp_vertex);
			errors++;
		end
		if (edge_job_counter_done != exp_edge) begin
			$display("MISMATCH at %0t: edge total %0d, expected %0d",
				$time, edge_job_counter_done, exp_edge);
			errors++;
		end
		foreach (remaining[v]) begin
			if (remaining[v] != 0) begin
				$display("Vertex %0d never got %0d of its read commands", v, remaining[v]);
				errors++;
			end
		end
	endtask

	task automatic end_test(input string name);
		tests++;
		$display("%s: %0d errors", name, errors - test_errors);
	endtask

	////////////////////////////////////////////////////////////
	// Bus monitor
	////////////////////////////////////////////////////////////

	always @(negedge clock) begin
		if (rstn && read_command_valid) begin
			commands_seen++;
			seen_vertex = int'(read_command_vertex);
			if (seen_vertex != last_vertex) begin
				switches++;
			end
			last_vertex = seen_vertex;
			if (!remaining.exists(seen_vertex) || remaining[seen_vertex] == 0) begin
				$display("Read command at %0t for vertex %0d, which has no edges left",
					$time, seen_vertex);
				errors++;
			end else begin
				if (read_command_address !== next_address[seen_vertex]) begin
					$display("MISMATCH at %0t: vertex %0d address %h, expected %h", $time,
						seen_vertex, read_command_address, next_address[seen_vertex]);
					errors++;
				end
				next_address[seen_vertex] = next_address[seen_vertex] + 1'b1;
				remaining[seen_vertex]--;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Tests
	////////////////////////////////////////////////////////////

	initial begin
		rstn = 1'b0;
		enabled_in = 1'b1;
		vertex_job_valid = 1'b0;
		vertex_job_id = '0;
		vertex_job_edge_offset = '0;
		vertex_job_edge_count = '0;
		read_command_bus_grant = 1'b1;
		last_vertex = -1;
		switches = 0;
		repeat (4) @(posedge clock);
		#2;
		rstn = 1'b1;
		step(2);

		test_errors = errors;
		submit_job(1, 12);
		check_totals();
		end_test("single job");

		// Random jobs under random grant
		test_errors = errors;
		random_grant = 1'b1;
		for (int i = 0; i < 20; i++) begin
			submit_job(100 + i, int'(random_bits(4)) + 1);
		end
		check_totals();
		random_grant = 1'b0;
		read_command_bus_grant = 1'b1;
		end_test("random jobs");

		test_errors = errors;
		submit_job(200, 0);
		submit_job(201, 3);
		submit_job(202, 0);
		check_totals();
		end_test("zero-edge jobs");

		// Grant held low while a job is walked
		test_errors = errors;
		read_command_bus_grant = 1'b0;
		snap_commands = commands_seen;
		submit_job(300, 20);
		stretch = 40 + int'(random_bits(6));
		for (int i = 0; i < stretch; i++) begin
			step(1);
			if (read_command_valid) begin
				$display("Read command issued at %0t while grant was low", $time);
				errors++;
			end
			if (!read_command_bus_request) begin
				$display("Bus request low at %0t with a command held", $time);
				errors++;
			end
		end
		if (commands_seen != snap_commands) begin
			$display("Commands went out at %0t before grant returned", $time);
			errors++;
		end
		read_command_bus_grant = 1'b1;
		check_totals();
		end_test("back-pressure");

		// Strobes while disabled are not in the model
		test_errors = errors;
		enabled_in = 1'b0;
		step(2);
		snap_commands = commands_seen;
		snap_vertex = int'(vertex_job_counter_done);
		snap_edge = int'(edge_job_counter_done);
		for (int i = 0; i < 3; i++) begin
			vertex_job_id = `GRAPH_VERTEX_BITS'(400 + i);
			vertex_job_edge_offset = random_bits(32);
			vertex_job_edge_count = `GRAPH_EDGE_COUNT_BITS'(random_bits(4) + 1);
			vertex_job_valid = 1'b1;
			step(1);
			vertex_job_valid = 1'b0;
			step(1);
		end
		step(20);
		if (commands_seen != snap_commands) begin
			$display("Read commands came from jobs sent while disabled");
			errors++;
		end
		if (vertex_job_counter_done != snap_vertex || edge_job_counter_done != snap_edge) begin
			$display("MISMATCH at %0t: counters moved while disabled", $time);
			errors++;
		end
		enabled_in = 1'b1;
		step(3);
		end_test("enable low");

		test_errors = errors;
		last_vertex = 500;
		switches = 0;
		submit_job(500, 40);
		submit_job(501, 40);
		check_totals();
		if (switches < 2) begin
			$display("Commands of the two long jobs were not interleaved on the bus");
			errors++;
		end
		end_test("both units");

		errors += i_graph_algorithm_control.i_graph_algorithm_control_sva.failures;
		$display("%0d tests, %0d read commands, %0d errors", tests, commands_seen, errors);
		if (errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- rtl/cu_arbiter_control.sv
`timescale 1ns/1ns
`default_nettype none

`include "graph_cu_params.svh"

module cu_arbiter_control (
	input  wire                            clock,
	input  wire                            rstn,
	input  wire                            job_valid,
	input  graph_cu_pkg::vertex_job_t      job,
	output logic                           job_request,
	input  wire  [`GRAPH_NUM_CU-1:0]       cu_busy,
	output logic [`GRAPH_NUM_CU-1:0]       cu_job_valid,
	output graph_cu_pkg::vertex_job_t      cu_job,
	input  wire  [`GRAPH_NUM_CU-1:0]       cu_command_valid,
	input  graph_cu_pkg::read_command_t    cu_command [0:`GRAPH_NUM_CU-1],
	output logic [`GRAPH_NUM_CU-1:0]       cu_command_ready,
	input  wire                            bus_grant,
	output logic                           bus_request,
	output logic                           command_valid,
	output graph_cu_pkg::read_command_t    command,
	input  wire  [`GRAPH_COUNTER_BITS-1:0] cu_vertex_done [0:`GRAPH_NUM_CU-1],
	input  wire  [`GRAPH_COUNTER_BITS-1:0] cu_edge_done [0:`GRAPH_NUM_CU-1],
	output logic [`GRAPH_COUNTER_BITS-1:0] vertex_done_total,
	output logic [`GRAPH_COUNTER_BITS-1:0] edge_done_total
);

	localparam int NUM_CU   = `GRAPH_NUM_CU;
	localparam int PTR_BITS = $clog2(NUM_CU);

	logic                      job_hold_valid;
	graph_cu_pkg::vertex_job_t job_hold;
	logic                      idle_found;
	logic [PTR_BITS-1:0]       idle_index;
	logic                      dispatch;

	logic                        cmd_hold_valid;
	graph_cu_pkg::read_command_t cmd_hold;
	logic [PTR_BITS-1:0]         rr_pointer;
	logic [PTR_BITS-1:0]         candidate;
	logic [PTR_BITS-1:0]         sel_index;
	logic                        sel_valid;
	logic                        release_hold;
	logic                        fill_ready;

	////////////////////////////////////////////////////////////
	// Job dispatch
	////////////////////////////////////////////////////////////

	// Lowest numbered idle unit wins
	always_comb begin
		idle_found = 1'b0;
		idle_index = '0;
		for (int i = NUM_CU - 1; i >= 0; i--) begin
			if (!cu_busy[i]) begin
				idle_found = 1'b1;
				idle_index = PTR_BITS'(i);
			end
		end
	end

	assign dispatch = job_hold_valid & idle_found;
	assign cu_job   = job_hold;

	always_comb begin
		for (int i = 0; i < NUM_CU; i++) begin
			cu_job_valid[i] = dispatch && (idle_index == PTR_BITS'(i));
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			job_hold_valid <= 1'b0;
		end else if (job_valid) begin
			job_hold_valid <= 1'b1;
		end else if (dispatch) begin
			job_hold_valid <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (job_valid) begin
			job_hold <= job;
		end
	end

	// Room for exactly one more job in flight
	assign job_request = ~job_hold_valid & ~job_valid & ~(&cu_busy);

	////////////////////////////////////////////////////////////
	// Read command round robin
	////////////////////////////////////////////////////////////

	// Search from the pointer, nearest pending unit last so it wins
	always_comb begin
		sel_valid = 1'b0;
		sel_index = rr_pointer;
		candidate = rr_pointer;
		for (int k = NUM_CU - 1; k >= 0; k--) begin
			candidate = PTR_BITS'((int'(rr_pointer) + k) % NUM_CU);
			if (cu_command_valid[candidate]) begin
				sel_valid = 1'b1;
				sel_index = candidate;
			end
		end
	end

	assign release_hold = cmd_hold_valid & bus_grant;
	// Refill in the same cycle the held command leaves
	assign fill_ready   = ~cmd_hold_valid | release_hold;

	always_comb begin
		for (int i = 0; i < NUM_CU; i++) begin
			cu_command_ready[i] = fill_ready && sel_valid && (sel_index == PTR_BITS'(i));
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			cmd_hold_valid <= 1'b0;
			rr_pointer     <= '0;
		end else if (fill_ready && sel_valid) begin
			cmd_hold_valid <= 1'b1;
			rr_pointer     <= (sel_index == PTR_BITS'(NUM_CU - 1)) ? '0 : sel_index + 1'b1;
		end else if (release_hold) begin
			cmd_hold_valid <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (fill_ready && sel_valid) begin
			cmd_hold <= cu_command[sel_index];
		end
	end

	assign bus_request   = cmd_hold_valid;
	assign command_valid = release_hold;
	assign command       = cmd_hold;

	////////////////////////////////////////////////////////////
	// Done totals
	////////////////////////////////////////////////////////////

	always_comb begin
		vertex_done_total = '0;
		edge_done_total   = '0;
		for (int i = 0; i < NUM_CU; i++) begin
			vertex_done_total = vertex_done_total + cu_vertex_done[i];
			edge_done_total   = edge_done_total + cu_edge_done[i];
		end
	end

endmodule

`default_nettype wire

//--- rtl/graph_algorithm_control.sv
`timescale 1ns/1ns
`default_nettype none

`include "graph_cu_params.svh"

module graph_algorithm_control (
	input  wire                                 clock,
	input  wire                                 rstn,
	input  wire                                 enabled_in,
	input  wire                                 vertex_job_valid,
	input  wire  [`GRAPH_VERTEX_BITS-1:0]       vertex_job_id,
	input  wire  [`GRAPH_ADDR_BITS-1:0]         vertex_job_edge_offset,
	input  wire  [`GRAPH_EDGE_COUNT_BITS-1:0]   vertex_job_edge_count,
	output logic                                vertex_job_request,
	input  wire                                 read_command_bus_grant,
	output logic                                read_command_bus_request,
	output logic                                read_command_valid,
	output logic [`GRAPH_VERTEX_BITS-1:0]       read_command_vertex,
	output logic [`GRAPH_ADDR_BITS-1:0]         read_command_address,
	output logic [`GRAPH_COUNTER_BITS-1:0]      vertex_job_counter_done,
	output logic [`GRAPH_COUNTER_BITS-1:0]      edge_job_counter_done
);

	logic enabled;
	logic read_command_bus_grant_latched;

	graph_cu_pkg::vertex_job_t   job_in;
	logic                        job_latched_valid;
	graph_cu_pkg::vertex_job_t   job_latched;
	logic                        job_request_int;

	logic [`GRAPH_NUM_CU-1:0]    cu_busy;
	logic [`GRAPH_NUM_CU-1:0]    cu_job_valid;
	graph_cu_pkg::vertex_job_t   cu_job;
	logic [`GRAPH_NUM_CU-1:0]    cu_command_valid;
	graph_cu_pkg::read_command_t cu_command [0:`GRAPH_NUM_CU-1];
	logic [`GRAPH_NUM_CU-1:0]    cu_command_ready;
	logic [`GRAPH_COUNTER_BITS-1:0] cu_vertex_done [0:`GRAPH_NUM_CU-1];
	logic [`GRAPH_COUNTER_BITS-1:0] cu_edge_done [0:`GRAPH_NUM_CU-1];

	logic                        bus_request_int;
	logic                        arb_command_valid;
	graph_cu_pkg::read_command_t arb_command;
	graph_cu_pkg::read_command_t out_command;
	logic [`GRAPH_COUNTER_BITS-1:0] vertex_done_total;
	logic [`GRAPH_COUNTER_BITS-1:0] edge_done_total;

	////////////////////////////////////////////////////////////
	// Enable and grant registers
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enabled                        <= 1'b0;
			read_command_bus_grant_latched <= 1'b0;
		end else begin
			enabled                        <= enabled_in;
			read_command_bus_grant_latched <= enabled & read_command_bus_grant;
		end
	end

	////////////////////////////////////////////////////////////
	// Input job latch
	////////////////////////////////////////////////////////////

	assign job_in.id          = vertex_job_id;
	assign job_in.edge_offset = vertex_job_edge_offset;
	assign job_in.edge_count  = vertex_job_edge_count;

	strobe_latch #(
		.payload_t(graph_cu_pkg::vertex_job_t)
	) i_job_latch (
		.clock      (clock),
		.rstn       (rstn),
		.enable     (enabled),
		.in_valid   (vertex_job_valid),
		.in_payload (job_in),
		.out_valid  (job_latched_valid),
		.out_payload(job_latched)
	);

	////////////////////////////////////////////////////////////
	// Compute units
	////////////////////////////////////////////////////////////

	for (genvar i = 0; i < `GRAPH_NUM_CU; i++) begin : g_walker
		vertex_edge_walker i_vertex_edge_walker (
			.clock            (clock),
			.rstn             (rstn),
			.job_valid        (cu_job_valid[i]),
			.job              (cu_job),
			.busy             (cu_busy[i]),
			.command_valid    (cu_command_valid[i]),
			.command          (cu_command[i]),
			.command_ready    (cu_command_ready[i]),
			.vertex_done_count(cu_vertex_done[i]),
			.edge_done_count  (cu_edge_done[i])
		);
	end

	cu_arbiter_control i_cu_arbiter_control (
		.clock            (clock),
		.rstn             (rstn),
		.job_valid        (job_latched_valid),
		.job              (job_latched),
		.job_request      (job_request_int),
		.cu_busy          (cu_busy),
		.cu_job_valid     (cu_job_valid),
		.cu_job           (cu_job),
		.cu_command_valid (cu_command_valid),
		.cu_command       (cu_command),
		.cu_command_ready (cu_command_ready),
		.bus_grant        (read_command_bus_grant_latched),
		.bus_request      (bus_request_int),
		.command_valid    (arb_command_valid),
		.command          (arb_command),
		.cu_vertex_done   (cu_vertex_done),
		.cu_edge_done     (cu_edge_done),
		.vertex_done_total(vertex_done_total),
		.edge_done_total  (edge_done_total)
	);

	////////////////////////////////////////////////////////////
	// Registered outputs
	////////////////////////////////////////////////////////////

	// An issued command is never dropped, so no enable here
	strobe_latch #(
		.payload_t(graph_cu_pkg::read_command_t)
	) i_command_latch (
		.clock      (clock),
		.rstn       (rstn),
		.enable     (1'b1),
		.in_valid   (arb_command_valid),
		.in_payload (arb_command),
		.out_valid  (read_command_valid),
		.out_payload(out_command)
	);

	assign read_command_vertex  = out_command.vertex;
	assign read_command_address = out_command.address;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			read_command_bus_request <= 1'b0;
			vertex_job_request       <= 1'b0;
			vertex_job_counter_done  <= '0;
			edge_job_counter_done    <= '0;
		end else begin
			read_command_bus_request <= bus_request_int;
			// No new jobs asked for while disabled
			vertex_job_request       <= enabled & job_request_int;
			vertex_job_counter_done  <= vertex_done_total;
			edge_job_counter_done    <= edge_done_total;
		end
	end

endmodule

`default_nettype wire

//--- rtl/graph_cu_params.svh
`ifndef GRAPH_CU_PARAMS_SVH
`define GRAPH_CU_PARAMS_SVH

////////////////////////////////////////////////////////////
// Field widths
////////////////////////////////////////////////////////////

// Vertex id
`define GRAPH_VERTEX_BITS 16
// Byte or word address into the edge array
`define GRAPH_ADDR_BITS 32
// Edges per vertex job
`define GRAPH_EDGE_COUNT_BITS 8
// Done counters
`define GRAPH_COUNTER_BITS 32

// Compute units side by side, at least 2
`define GRAPH_NUM_CU 2

`endif

//--- rtl/graph_cu_pkg.sv
`default_nettype none

`include "graph_cu_params.svh"

package graph_cu_pkg;

	////////////////////////////////////////////////////////////
	// Payload types, each carried next to its own valid bit
	////////////////////////////////////////////////////////////

	// One vertex to walk
	typedef struct packed {
		logic [`GRAPH_VERTEX_BITS-1:0]     id;
		logic [`GRAPH_ADDR_BITS-1:0]       edge_offset;
		logic [`GRAPH_EDGE_COUNT_BITS-1:0] edge_count;
	} vertex_job_t;

	// One edge read toward memory
	typedef struct packed {
		logic [`GRAPH_VERTEX_BITS-1:0] vertex;
		logic [`GRAPH_ADDR_BITS-1:0]   address;
	} read_command_t;

endpackage

`default_nettype wire

//--- rtl/strobe_latch.sv
`timescale 1ns/1ns
`default_nettype none

module strobe_latch #(
	parameter type payload_t = logic
) (
	input  wire      clock,
	input  wire      rstn,
	input  wire      enable,
	input  wire      in_valid,
	input  payload_t in_payload,
	output logic     out_valid,
	output payload_t out_payload
);

	// Valid bit, forced low while disabled
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= enable & in_valid;
		end
	end

	// Payload follows the input every cycle
	always_ff @(posedge clock) begin
		out_payload <= in_payload;
	end

endmodule

`default_nettype wire

//--- rtl/vertex_edge_walker.sv
`timescale 1ns/1ns
`default_nettype none

`include "graph_cu_params.svh"

module vertex_edge_walker (
	input  wire                              clock,
	input  wire                              rstn,
	input  wire                              job_valid,
	input  graph_cu_pkg::vertex_job_t        job,
	output logic                             busy,
	output logic                             command_valid,
	output graph_cu_pkg::read_command_t      command,
	input  wire                              command_ready,
	output logic [`GRAPH_COUNTER_BITS-1:0]   vertex_done_count,
	output logic [`GRAPH_COUNTER_BITS-1:0]   edge_done_count
);

	localparam logic [`GRAPH_EDGE_COUNT_BITS-1:0] LAST_EDGE = 1;

	logic [`GRAPH_VERTEX_BITS-1:0]     vertex_id;
	logic [`GRAPH_ADDR_BITS-1:0]       edge_address;
	logic [`GRAPH_EDGE_COUNT_BITS-1:0] remaining_edges;

	logic load_job;
	logic transfer;

	assign load_job = job_valid & ~busy;
	assign transfer = busy & command_ready;

	////////////////////////////////////////////////////////////
	// Control and counters
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			busy              <= 1'b0;
			vertex_done_count <= '0;
			edge_done_count   <= '0;
		end else begin
			if (load_job) begin
				// Zero edges finish right away
				if (job.edge_count == '0) begin
					vertex_done_count <= vertex_done_count + 1'b1;
				end else begin
					busy <= 1'b1;
				end
			end else if (transfer) begin
				edge_done_count <= edge_done_count + 1'b1;
				if (remaining_edges == LAST_EDGE) begin
					busy              <= 1'b0;
					vertex_done_count <= vertex_done_count + 1'b1;
				end
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Walk state
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (load_job) begin
			vertex_id       <= job.id;
			edge_address    <= job.edge_offset;
			remaining_edges <= job.edge_count;
		end else if (transfer) begin
			edge_address    <= edge_address + 1'b1;
			remaining_edges <= remaining_edges - 1'b1;
		end
	end

	// One command per edge, held until taken
	assign command_valid   = busy;
	assign command.vertex  = vertex_id;
	assign command.address = edge_address;

endmodule

`default_nettype wire

//--- sim.f
+incdir+rtl
rtl/graph_cu_pkg.sv
rtl/strobe_latch.sv
rtl/vertex_edge_walker.sv
rtl/cu_arbiter_control.sv
rtl/graph_algorithm_control.sv
bench/graph_algorithm_control_sva.sv
bench/graph_algorithm_control_tb.sv
